// ==== hw/conv_window_pkg.sv ====
// Shared geometry defaults and scan FSM codes for the 5x5 convolution window generator
`default_nettype none

package conv_window_pkg;

    // Frame geometry defaults, picked up by the top level parameters
    localparam int DEF_IMG_W = 32;  // Pixels per input row
    localparam int DEF_IMG_H = 32;  // Input rows per frame
    localparam int DEF_KSIZE = 5;   // Window side
    localparam int DEF_PIX_W = 8;   // Bits per pixel

    // Read side FSM encoding
    localparam logic [1:0] SCAN_IDLE = 2'd0;  // Waiting for a frame start
    localparam logic [1:0] SCAN_LOAD = 2'd1;  // First KSIZE rows loading
    localparam logic [1:0] SCAN_ROW  = 2'd2;  // Issuing windows of one output row

    // Waits for the prefetch, then moves the read base down one line
    localparam logic [1:0] SCAN_ROLL = 2'd3;

endpackage

`default_nettype wire

// ==== hw/line_buffer_bank.sv ====
// Circular line storage of the window generator; one pixel write port and a registered window read
`timescale 1ns/1ps
`default_nettype none

module line_buffer_bank #(
    parameter int  IMG_W  = conv_window_pkg::DEF_IMG_W,
    parameter int  KSIZE  = conv_window_pkg::DEF_KSIZE,
    parameter int  PIX_W  = conv_window_pkg::DEF_PIX_W,
    localparam int LINE_W = $clog2(KSIZE + 1),
    localparam int COL_W  = $clog2(IMG_W)
) (
    input  wire logic                       clk,
    input  wire logic                       i_wr_en,
    input  wire logic [LINE_W-1:0]          i_wr_line,
    input  wire logic [COL_W-1:0]           i_wr_col,
    input  wire logic [PIX_W-1:0]           i_pixel,
    input  wire logic                       i_rd_en,
    input  wire logic [LINE_W-1:0]          i_rd_base,
    input  wire logic [COL_W-1:0]           i_rd_col,
    output logic [KSIZE*KSIZE*PIX_W-1:0]    o_window
);

    localparam int LINES = KSIZE + 1;

    localparam logic [LINE_W:0] LINES_EXT = (LINE_W + 1)'(LINES);

    logic [PIX_W-1:0]  mem [LINES][IMG_W];
    logic [LINE_W-1:0] line_sel [KSIZE];  // Physical line of each window row

    always_ff @(posedge clk) begin
        if (i_wr_en) begin
            mem[i_wr_line][i_wr_col] <= i_pixel;
        end
    end

    // Window row i comes from line base+i, wrapped around the ring
    always_comb begin : calc_lines
        logic [LINE_W:0] line_sum;
        line_sum = '0;
        for (int i = 0; i < KSIZE; i++) begin
            line_sum = {1'b0, i_rd_base} + (LINE_W + 1)'(i);
            if (line_sum >= LINES_EXT) begin
                line_sum = line_sum - LINES_EXT;
            end
            line_sel[i] = line_sum[LINE_W-1:0];
        end
    end

    // Slot i*KSIZE+j holds row i, column j, slot 0 in the low bits
    always_ff @(posedge clk) begin
        if (i_rd_en) begin
            for (int i = 0; i < KSIZE; i++) begin
                for (int j = 0; j < KSIZE; j++) begin
                    o_window[(i*KSIZE + j)*PIX_W +: PIX_W] <=
                        mem[line_sel[i]][i_rd_col + COL_W'(j)];
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/line_load_ctrl.sv ====
// Write side of the window generator; takes raster pixels and steers them into the line bank
`timescale 1ns/1ps
`default_nettype none

module line_load_ctrl #(
    parameter int  IMG_W  = conv_window_pkg::DEF_IMG_W,
    parameter int  IMG_H  = conv_window_pkg::DEF_IMG_H,
    parameter int  KSIZE  = conv_window_pkg::DEF_KSIZE,
    localparam int LINE_W = $clog2(KSIZE + 1),
    localparam int COL_W  = $clog2(IMG_W)
) (
    input  wire logic              clk,
    input  wire logic              reset_n,
    input  wire logic              i_start,
    input  wire logic              i_roll,
    input  wire logic              i_pixel_valid,
    output logic                   o_pixel_ready,
    output logic                   o_wr_en,
    output logic [LINE_W-1:0]      o_wr_line,
    output logic [COL_W-1:0]       o_wr_col,
    output logic                   o_rows_primed,
    output logic                   o_prefetch_busy
);

    localparam int LINES = KSIZE + 1;
    localparam int ROW_W = $clog2(IMG_H + 1);  // Counts up to IMG_H

    localparam logic [COL_W-1:0]  LAST_COL      = COL_W'(IMG_W - 1);
    localparam logic [ROW_W-1:0]  LAST_LOAD_ROW = ROW_W'(KSIZE - 1);
    localparam logic [ROW_W-1:0]  TOTAL_ROWS    = ROW_W'(IMG_H);
    localparam logic [LINE_W-1:0] SPARE_LINE    = LINE_W'(KSIZE);
    localparam logic [LINE_W-1:0] LAST_LINE     = LINE_W'(LINES - 1);

    logic [COL_W-1:0]  wr_col;
    logic [ROW_W-1:0]  in_row;   // Input rows fully taken so far
    logic [LINE_W-1:0] wr_line;
    logic              pending;  // A row is wanted from the source
    logic              primed;   // First KSIZE rows are in the bank
    logic              accept;

    assign accept = i_pixel_valid && pending;

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            wr_col  <= '0;
            in_row  <= '0;
            wr_line <= '0;
            pending <= 1'b0;
            primed  <= 1'b0;
        end else if (i_start) begin
            wr_col  <= '0;
            in_row  <= '0;
            wr_line <= '0;
            pending <= 1'b1;  // Initial load starts right away
            primed  <= 1'b0;
        end else if (i_roll) begin
            // Spare line moves along with the read base
            wr_line <= (wr_line == LAST_LINE) ? '0 : wr_line + 1'b1;
            pending <= (in_row < TOTAL_ROWS);
        end else if (accept) begin
            if (wr_col == LAST_COL) begin
                wr_col <= '0;
                in_row <= in_row + 1'b1;
                if (!primed) begin
                    if (in_row == LAST_LOAD_ROW) begin
                        // Load complete, keep pending for the first prefetch
                        primed  <= 1'b1;
                        wr_line <= SPARE_LINE;
                    end else begin
                        wr_line <= wr_line + 1'b1;
                    end
                end else begin
                    pending <= 1'b0;  // Prefetched row is complete
                end
            end else begin
                wr_col <= wr_col + 1'b1;
            end
        end
    end

    assign o_pixel_ready   = pending;
    assign o_wr_en         = accept;
    assign o_wr_line       = wr_line;
    assign o_wr_col        = wr_col;
    assign o_rows_primed   = primed;
    assign o_prefetch_busy = pending;

endmodule

`default_nettype wire

// ==== hw/window_scan_ctrl.sv ====
// Read side FSM of the window generator; sequences window reads and the output strobes
`timescale 1ns/1ps
`default_nettype none

module window_scan_ctrl #(
    parameter int  IMG_W  = conv_window_pkg::DEF_IMG_W,
    parameter int  IMG_H  = conv_window_pkg::DEF_IMG_H,
    parameter int  KSIZE  = conv_window_pkg::DEF_KSIZE,
    localparam int LINE_W = $clog2(KSIZE + 1),
    localparam int COL_W  = $clog2(IMG_W)
) (
    input  wire logic              clk,
    input  wire logic              reset_n,
    input  wire logic              i_start,
    input  wire logic              i_conv_ready,
    input  wire logic              i_rows_primed,
    input  wire logic              i_prefetch_busy,
    output logic                   o_start_load,
    output logic                   o_roll,
    output logic                   o_rd_en,
    output logic [LINE_W-1:0]      o_rd_base,
    output logic [COL_W-1:0]       o_rd_col,
    output logic                   o_conv_valid,
    output logic                   o_conv_row_start,
    output logic                   o_conv_row_end,
    output logic                   o_done
);

    import conv_window_pkg::*;

    localparam int LINES = KSIZE + 1;
    localparam int ORW   = $clog2(IMG_H - KSIZE + 1);

    localparam logic [COL_W-1:0]  LAST_COL  = COL_W'(IMG_W - KSIZE);
    localparam logic [ORW-1:0]    LAST_ROW  = ORW'(IMG_H - KSIZE);
    localparam logic [LINE_W-1:0] LAST_LINE = LINE_W'(LINES - 1);

    logic [1:0]        state;
    logic [COL_W-1:0]  win_col;
    logic [ORW-1:0]    out_row;
    logic [LINE_W-1:0] rd_base;  // Line holding the top row of the window
    logic              issue;

    // Leaving SCAN_ROW marks the row as finished, so no extra flag is kept
    assign issue = (state == SCAN_ROW) && i_conv_ready;

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state            <= SCAN_IDLE;
            win_col          <= '0;
            out_row          <= '0;
            rd_base          <= '0;
            o_conv_valid     <= 1'b0;
            o_conv_row_start <= 1'b0;
            o_conv_row_end   <= 1'b0;
            o_done           <= 1'b0;
        end else begin
            // Strobes line up with the bank's window register
            o_conv_valid     <= issue;
            o_conv_row_start <= issue && (win_col == '0);
            o_conv_row_end   <= issue && (win_col == LAST_COL);

            // One cycle after the final window
            o_done <= o_conv_valid && o_conv_row_end && (out_row == LAST_ROW);

            case (state)
                SCAN_IDLE: begin
                    if (i_start) begin
                        state   <= SCAN_LOAD;
                        win_col <= '0;
                        out_row <= '0;
                        rd_base <= '0;
                    end
                end
                SCAN_LOAD: begin
                    if (i_rows_primed) begin
                        state <= SCAN_ROW;
                    end
                end
                SCAN_ROW: begin
                    if (issue) begin
                        if (win_col == LAST_COL) begin
                            win_col <= '0;
                            state   <= (out_row == LAST_ROW) ? SCAN_IDLE : SCAN_ROLL;
                        end else begin
                            win_col <= win_col + 1'b1;
                        end
                    end
                end
                SCAN_ROLL: begin
                    if (!i_prefetch_busy) begin
                        rd_base <= (rd_base == LAST_LINE) ? '0 : rd_base + 1'b1;
                        out_row <= out_row + 1'b1;
                        state   <= SCAN_ROW;
                    end
                end
                default: state <= SCAN_IDLE;
            endcase
        end
    end

    assign o_start_load = (state == SCAN_IDLE) && i_start;
    assign o_roll       = (state == SCAN_ROLL) && !i_prefetch_busy;  // Same cycle as base step
    assign o_rd_en      = issue;
    assign o_rd_base    = rd_base;
    assign o_rd_col     = win_col;

endmodule

`default_nettype wire

// ==== hw/conv_window_gen.sv ====
// Top level of the line-buffer window generator; instantiate this to stream 5x5 windows
`timescale 1ns/1ps
`default_nettype none

module conv_window_gen #(
    parameter int IMG_W = conv_window_pkg::DEF_IMG_W,
    parameter int IMG_H = conv_window_pkg::DEF_IMG_H,
    parameter int KSIZE = conv_window_pkg::DEF_KSIZE,
    parameter int PIX_W = conv_window_pkg::DEF_PIX_W
) (
    input  wire logic                           clk,
    input  wire logic                           reset_n,
    input  wire logic                           i_start,
    input  wire logic                           i_pixel_valid,
    input  wire logic [PIX_W-1:0]               i_pixel,
    input  wire logic                           i_conv_ready,
    output logic                                o_pixel_ready,
    output logic                                o_conv_valid,
    output logic                                o_conv_row_start,
    output logic                                o_conv_row_end,
    output logic                                o_done,
    output logic [KSIZE*KSIZE*PIX_W-1:0]        o_window
);

    localparam int LINE_W = $clog2(KSIZE + 1);
    localparam int COL_W  = $clog2(IMG_W);

    // Scanner to loader
    logic              start_load;
    logic              roll;

    // Loader to scanner
    logic              rows_primed;
    logic              prefetch_busy;

    // Write port of the bank
    logic              wr_en;
    logic [LINE_W-1:0] wr_line;
    logic [COL_W-1:0]  wr_col;

    // Read port of the bank
    logic              rd_en;
    logic [LINE_W-1:0] rd_base;
    logic [COL_W-1:0]  rd_col;

    line_load_ctrl #(
        .IMG_W (IMG_W),
        .IMG_H (IMG_H),
        .KSIZE (KSIZE)
    ) line_load_ctrl_inst (
        .clk             (clk),
        .reset_n         (reset_n),
        .i_start         (start_load),
        .i_roll          (roll),
        .i_pixel_valid   (i_pixel_valid),
        .o_pixel_ready   (o_pixel_ready),
        .o_wr_en         (wr_en),
        .o_wr_line       (wr_line),
        .o_wr_col        (wr_col),
        .o_rows_primed   (rows_primed),
        .o_prefetch_busy (prefetch_busy)
    );

    window_scan_ctrl #(
        .IMG_W (IMG_W),
        .IMG_H (IMG_H),
        .KSIZE (KSIZE)
    ) window_scan_ctrl_inst (
        .clk              (clk),
        .reset_n          (reset_n),
        .i_start          (i_start),
        .i_conv_ready     (i_conv_ready),
        .i_rows_primed    (rows_primed),
        .i_prefetch_busy  (prefetch_busy),
        .o_start_load     (start_load),
        .o_roll           (roll),
        .o_rd_en          (rd_en),
        .o_rd_base        (rd_base),
        .o_rd_col         (rd_col),
        .o_conv_valid     (o_conv_valid),
        .o_conv_row_start (o_conv_row_start),
        .o_conv_row_end   (o_conv_row_end),
        .o_done           (o_done)
    );

    line_buffer_bank #(
        .IMG_W (IMG_W),
        .KSIZE (KSIZE),
        .PIX_W (PIX_W)
    ) line_buffer_bank_inst (
        .clk       (clk),
        .i_wr_en   (wr_en),
        .i_wr_line (wr_line),
        .i_wr_col  (wr_col),
        .i_pixel   (i_pixel),
        .i_rd_en   (rd_en),
        .i_rd_base (rd_base),
        .i_rd_col  (rd_col),
        .o_window  (o_window)
    );

endmodule

`default_nettype wire

// ==== tests/tb_conv_window_gen.sv ====
// Self-checking testbench for conv_window_gen; runs every frame listed in the stim file
`timescale 1ns/1ps
`default_nettype none

module tb_conv_window_gen;

    localparam int IMG_W       = 32;
    localparam int IMG_H       = 32;
    localparam int KSIZE       = 5;
    localparam int PIX_W       = 8;
    localparam int PIXELS      = IMG_W * IMG_H;
    localparam int WIN_PER_ROW = IMG_W - KSIZE + 1;
    localparam int WIN_TOTAL   = WIN_PER_ROW * (IMG_H - KSIZE + 1);
    localparam int FRAMES      = 8;  // Lines in the stim file
    localparam int DRAIN       = 4;  // Quiet cycles checked after each frame

    logic                         clk = 1'b0;
    logic                         reset_n;
    logic                         i_start;
    logic                         i_pixel_valid;
    logic [PIX_W-1:0]             i_pixel;
    logic                         i_conv_ready;
    logic                         o_pixel_ready;
    logic                         o_conv_valid;
    logic                         o_conv_row_start;
    logic                         o_conv_row_end;
    logic                         o_done;
    logic [KSIZE*KSIZE*PIX_W-1:0] o_window;

    logic [31:0]      stim [0:4*FRAMES-1];  // Seed, valid duty, ready duty, windows
    logic [PIX_W-1:0] image [0:PIXELS-1];   // Reference frame of the current run
    integer           seed;
    int unsigned      cycle_count = 0;
    int unsigned      cycle_limit = 0;

    always #4 clk = ~clk;

    conv_window_gen conv_window_gen_inst (
        .clk              (clk),
        .reset_n          (reset_n),
        .i_start          (i_start),
        .i_pixel_valid    (i_pixel_valid),
        .i_pixel          (i_pixel),
        .i_conv_ready     (i_conv_ready),
        .o_pixel_ready    (o_pixel_ready),
        .o_conv_valid     (o_conv_valid),
        .o_conv_row_start (o_conv_row_start),
        .o_conv_row_end   (o_conv_row_end),
        .o_done           (o_done),
        .o_window         (o_window)
    );

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
            $display("Timeout after %0d cycles, the DUT stopped making progress", cycle_count);
            $display("** FAIL **");
            $fatal(1, "Cycle limit reached");
        end
    end

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("Fail at %0t: %s, got 0x%0h, expected 0x%0h", $time, what, actual, expected);
            $display("** FAIL **");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    // True for about duty percent of the calls
    function automatic logic draw_duty(input logic [31:0] duty);
        logic [31:0] rnd;
        rnd = $random(seed);
        return (rnd % 100) < duty;
    endfunction

    function automatic int unsigned frame_budget(input logic [31:0] v_duty,
                                                 input logic [31:0] r_duty);
        return 4 * (PIXELS * 100 / v_duty + WIN_TOTAL * 100 / r_duty) + 64;
    endfunction

    task automatic expect_outputs_idle(input string when_txt);
        check_value(32'(o_pixel_ready), 32'd0, {"pixel ready low ", when_txt});
        check_value(32'(o_conv_valid), 32'd0, {"window valid low ", when_txt});
        check_value(32'(o_conv_row_start), 32'd0, {"row start low ", when_txt});
        check_value(32'(o_conv_row_end), 32'd0, {"row end low ", when_txt});
        check_value(32'(o_done), 32'd0, {"done low ", when_txt});
    endtask

    task automatic run_frame(input int f);
        logic [31:0]      v_duty;
        logic [31:0]      r_duty;
        logic [31:0]      rnd;
        logic [PIX_W-1:0] got;
        logic [PIX_W-1:0] want;
        logic             prev_ready;
        logic             done_due;
        logic             frame_over;
        int               pix_idx;
        int               win_count;
        int               win_row;
        int               win_col;

        v_duty     = stim[4*f+1];
        r_duty     = stim[4*f+2];
        pix_idx    = 0;
        win_count  = 0;
        win_row    = 0;
        win_col    = 0;
        prev_ready = 1'b0;
        done_due   = 1'b0;
        frame_over = 1'b0;

        seed = seed ^ stim[4*f];
        for (int k = 0; k < PIXELS; k++) begin
            rnd = $random(seed);
            image[k] = rnd[PIX_W-1:0];
        end

        @(posedge clk);
        i_start       <= 1'b1;
        i_pixel_valid <= 1'b0;  // No stale pixel while the load arms
        i_conv_ready  <= 1'b0;
        @(posedge clk);
        i_start <= 1'b0;
        @(posedge clk);
        check_value(32'(o_pixel_ready), 32'd1, "pixel ready one cycle after start");
        i_pixel       <= image[0];
        i_pixel_valid <= draw_duty(v_duty);
        i_conv_ready  <= draw_duty(r_duty);

        while (!frame_over) begin
            @(posedge clk);
            // Sampled values are the ones held through the cycle that just ended
            if (i_pixel_valid && o_pixel_ready) begin
                check_value(32'(pix_idx < PIXELS), 32'd1, "pixel accepted after the frame");
                pix_idx++;
            end
            check_value(32'(o_done), 32'(done_due), "done one cycle after the last window");
            if (o_conv_valid) begin
                check_value(32'(prev_ready), 32'd1, "window with consumer not ready before");
                check_value(32'(win_count < WIN_TOTAL), 32'd1, "window past the frame total");
                check_value(32'(o_conv_row_start), 32'(win_col == 0), "row start strobe");
                check_value(32'(o_conv_row_end), 32'(win_col == WIN_PER_ROW - 1),
                            "row end strobe");
                for (int i = 0; i < KSIZE; i++) begin
                    for (int j = 0; j < KSIZE; j++) begin
                        got  = o_window[(i*KSIZE + j)*PIX_W +: PIX_W];
                        want = image[(win_row + i)*IMG_W + win_col + j];
                        check_value(32'(got), 32'(want),
                                    $sformatf("frame %0d window r%0d c%0d slot %0d",
                                              f, win_row, win_col, i*KSIZE + j));
                    end
                end
                win_count++;
                if (win_col == WIN_PER_ROW - 1) begin
                    win_col = 0;
                    win_row++;
                end else begin
                    win_col++;
                end
            end else begin
                check_value(32'(o_conv_row_start), 32'd0, "row start without a window");
                check_value(32'(o_conv_row_end), 32'd0, "row end without a window");
            end
            done_due   = o_conv_valid && (win_count == WIN_TOTAL);
            prev_ready = i_conv_ready;
            frame_over = o_done;

            i_pixel       <= (pix_idx < PIXELS) ? image[pix_idx] : '0;
            i_pixel_valid <= draw_duty(v_duty);
            i_conv_ready  <= draw_duty(r_duty);
        end

        check_value(32'(pix_idx), 32'(PIXELS), "pixels accepted in the frame");
        check_value(32'(win_count), stim[4*f+3], "windows in the frame");

        // Offer data and demand windows while the DUT must stay quiet
        i_pixel_valid <= 1'b1;
        i_conv_ready  <= 1'b1;
        repeat (DRAIN) begin
            @(posedge clk);
            expect_outputs_idle("after done");
        end
    endtask

    initial begin
        reset_n       = 1'b0;
        i_start       = 1'b0;
        i_pixel_valid = 1'b0;
        i_pixel       = '0;
        i_conv_ready  = 1'b0;
        seed          = 32'hd538;

        $readmemh("tests/conv_window_stim.txt", stim);
        for (int f = 0; f < FRAMES; f++) begin
            if ($isunknown(stim[4*f+3]) || stim[4*f+1] == 0 || stim[4*f+2] == 0) begin
                $display("Stim file is missing or frame %0d has a zero duty", f);
                $display("** FAIL **");
                $fatal(1, "Bad stimulus");
            end
            cycle_limit += frame_budget(stim[4*f+1], stim[4*f+2]);
        end
        cycle_limit += 64;  // Reset and idle cycles

        repeat (2) @(posedge clk);
        reset_n <= 1'b1;
        repeat (3) begin
            @(posedge clk);
            expect_outputs_idle("after reset");
        end

        for (int f = 0; f < FRAMES; f++) begin
            run_frame(f);
        end

        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tests/conv_window_stim.txt ====
// One frame per line: image seed, valid duty, ready duty, expected windows
// All values hex, duties in percent of cycles (64 is 100 percent)
0000a1b2 64 64 310
00003c4d 32 64 310
00005e6f 64 32 310
0000129a 4b 19 310
00007e01 19 4b 310
0000c0de 0a 50 310
00004242 50 0a 310
0000beef 32 32 310

// ==== conv_window_gen.f ====
hw/conv_window_pkg.sv
hw/line_buffer_bank.sv
hw/line_load_ctrl.sv
hw/window_scan_ctrl.sv
hw/conv_window_gen.sv
tests/tb_conv_window_gen.sv

// ==== Makefile ====
TOP := tb_conv_window_gen

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f conv_window_gen.f --top-module $(TOP)

sim:
	verilator --binary --timing -f conv_window_gen.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -F '** PASS **' > /dev/null

clean:
	rm -rf obj_dir
